//--- Makefile
# Verilator build and run of the colour correction matrix testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_ccm
FILELIST  := project.f

BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := All tests passed

# sources come from the file list, headers from its include directory
SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard rtl/*.svh)

.PHONY: all run check clean

all: $(SIM)

# rebuilt only when a source, a header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log is searched for the pass message
run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@$(MAKE) --no-print-directory check

check:
	@grep -qx '$(PASS_MSG)' $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- project.f
+incdir+rtl
rtl/pixel_pkg.sv
rtl/ccm_coeff_pkg.sv
rtl/ccm_coeff_bank.sv
rtl/ccm_row_mac.sv
rtl/ccm_clamp_stage.sv
rtl/ccm_top.sv
tests/tb_clock_gen.sv
tests/tb_ccm.sv

//--- rtl/ccm_clamp_stage.sv
`timescale 1ns/10ps
`include "ccm_defs.svh"

module ccm_clamp_stage (
   input  logic                                            clk,
   input  logic                                            resetb,
   input  logic                                            enable,
   input  pixel_pkg::pixel_beat_t                          beat_q,
   input  ccm_coeff_pkg::mac_sum_t [`CCM_CHANNELS-1:0]     sums,
   output pixel_pkg::pixel_beat_t                          pixel_out
);

   // sideband delay, matches the two MAC stages
   pixel_pkg::pixel_beat_t beat_d1;
   pixel_pkg::pixel_beat_t beat_d2;

   // clamped result of all three rows
   pixel_pkg::rgb_t corr_rgb;

   // drop the fraction by taking the integer bits, which floors a signed value
   // then saturate into the unsigned pixel range
   function automatic pixel_pkg::pixel_t clamp_pixel(input ccm_coeff_pkg::mac_sum_t s);
      pixel_pkg::pixel_t res;
      if (s[`CCM_SUM_WIDTH-1]) begin
         // negative, floor is below zero
         res = '0;
      end else if (|s[`CCM_SUM_WIDTH-2:`CCM_COEFF_FRAC+`CCM_PIXEL_WIDTH]) begin
         // integer part above full scale
         res = '1;
      end else begin
         res = s[`CCM_COEFF_FRAC+`CCM_PIXEL_WIDTH-1:`CCM_COEFF_FRAC];
      end
      return res;
   endfunction

   // sums index follows the rgb order, 0 is r
   assign corr_rgb.r = clamp_pixel(sums[0]);
   assign corr_rgb.g = clamp_pixel(sums[1]);
   assign corr_rgb.b = clamp_pixel(sums[2]);

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         beat_d1 <= '0;
         beat_d2 <= '0;
      end else begin
         beat_d1 <= beat_q;
         beat_d2 <= beat_d1;
      end
   end

   // output register
   // enable is sampled here, on the same edge as the beat it selects for
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         pixel_out <= '0;
      end else begin
         pixel_out.dv    <= beat_d2.dv;
         pixel_out.dtype <= beat_d2.dtype;
         pixel_out.meta  <= beat_d2.meta;
         // bypass hands back the raw pixel, it left the bank three edges ago
         pixel_out.rgb   <= enable ? corr_rgb : beat_d2.rgb;
      end
   end

   // output strobe trails the bank's beat by both delay stages and the output register
   a_dv_follows : assert property (
      @(posedge clk) disable iff (!resetb)
      pixel_out.dv == $past(beat_q.dv, 3)
   ) else $error("pixel_out.dv out of step with the sideband delay");

endmodule

//--- rtl/ccm_coeff_bank.sv
`timescale 1ns/10ps
`include "ccm_defs.svh"

module ccm_coeff_bank (
   input  logic                                               clk,
   input  logic                                               resetb,
   input  logic                                               coeff_we,
   input  ccm_coeff_pkg::coeff_addr_t                         coeff_addr,
   input  ccm_coeff_pkg::coeff_t                              coeff_data,
   input  pixel_pkg::pixel_beat_t                             pixel_in,
   output pixel_pkg::pixel_beat_t                             beat_q,
   output ccm_coeff_pkg::coeff_row_t [`CCM_CHANNELS-1:0]      rows
);

   // nine live coefficients, row-major like the write address
   ccm_coeff_pkg::coeff_t coeff_q [`CCM_CHANNELS*`CCM_CHANNELS];

   // write decode, unmapped addresses fall through
   logic coeff_hit;

   assign coeff_hit = coeff_we && (coeff_addr < `CCM_CHANNELS*`CCM_CHANNELS);

   // register file
   // reset loads the identity matrix, diagonal entries sit every CHANNELS+1 slots
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         for (int i = 0; i < `CCM_CHANNELS*`CCM_CHANNELS; i++) begin
            if (i % (`CCM_CHANNELS + 1) == 0) begin
               coeff_q[i] <= ccm_coeff_pkg::coeff_t'(1 << `CCM_COEFF_FRAC);
            end else begin
               coeff_q[i] <= '0;
            end
         end
      end else if (coeff_hit) begin
         coeff_q[coeff_addr] <= coeff_data;
      end
   end

   // beat and row snapshot are taken on the same edge
   // a write on that same edge lands in coeff_q only, so it hits later beats
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         beat_q <= '0;
         for (int ch = 0; ch < `CCM_CHANNELS; ch++) begin
            rows[ch].cr <= (ch == 0) ? ccm_coeff_pkg::coeff_t'(1 << `CCM_COEFF_FRAC) : '0;
            rows[ch].cg <= (ch == 1) ? ccm_coeff_pkg::coeff_t'(1 << `CCM_COEFF_FRAC) : '0;
            rows[ch].cb <= (ch == 2) ? ccm_coeff_pkg::coeff_t'(1 << `CCM_COEFF_FRAC) : '0;
         end
      end else begin
         beat_q <= pixel_in;
         // row ch weights the r, g and b inputs of output channel ch
         for (int ch = 0; ch < `CCM_CHANNELS; ch++) begin
            rows[ch].cr <= coeff_q[ch*`CCM_CHANNELS + 0];
            rows[ch].cg <= coeff_q[ch*`CCM_CHANNELS + 1];
            rows[ch].cb <= coeff_q[ch*`CCM_CHANNELS + 2];
         end
      end
   end

   // software must never write outside the 3x3 map
   a_coeff_addr_valid : assert property (
      @(posedge clk) disable iff (!resetb)
      coeff_we |-> (coeff_addr < `CCM_CHANNELS*`CCM_CHANNELS)
   ) else $error("coefficient write to unmapped address %0d", coeff_addr);

endmodule

//--- rtl/ccm_coeff_pkg.sv
`include "ccm_defs.svh"

package ccm_coeff_pkg;

   // signed fixed point gain, CCM_COEFF_FRAC fractional bits
   typedef logic signed [`CCM_COEFF_WIDTH-1:0] coeff_t;

   // row-major write address, row = output channel, column = input channel
   // 0 RR, 1 RG, 2 RB, 3 GR, 4 GG, 5 GB, 6 BR, 7 BG, 8 BB
   // 9..15 are not mapped
   typedef logic [$clog2(`CCM_CHANNELS*`CCM_CHANNELS)-1:0] coeff_addr_t;

   // weights one output channel applies to the r, g and b inputs
   typedef struct packed {
      coeff_t cr;
      coeff_t cg;
      coeff_t cb;
   } coeff_row_t;

   // exact dot product of one row with one pixel
   // still carries CCM_COEFF_FRAC fractional bits
   typedef logic signed [`CCM_SUM_WIDTH-1:0] mac_sum_t;

endpackage

//--- rtl/ccm_defs.svh
`ifndef CCM_DEFS_SVH
`define CCM_DEFS_SVH

// bits per colour channel, unsigned
`define CCM_PIXEL_WIDTH 10

// signed coefficient width and its fractional bits
// with 5 fractional bits a gain of 1.0 is 32
`define CCM_COEFF_WIDTH 8
`define CCM_COEFF_FRAC  5

// sideband widths carried with every beat
`define CCM_DTYPE_WIDTH 4
`define CCM_META_WIDTH  16

// colour channels, also the number of matrix rows and columns
`define CCM_CHANNELS 3

// signed pixel (pixel + 1) times coefficient, plus 2 bits for the 3-term sum
`define CCM_SUM_WIDTH (`CCM_PIXEL_WIDTH + 1 + `CCM_COEFF_WIDTH + 2)

`endif

//--- rtl/ccm_row_mac.sv
`timescale 1ns/10ps
`include "ccm_defs.svh"

module ccm_row_mac (
   input  logic                        clk,
   input  logic                        resetb,
   input  pixel_pkg::pixel_beat_t      beat,
   input  ccm_coeff_pkg::coeff_row_t   row,
   output ccm_coeff_pkg::mac_sum_t     sum
);

   // signed pixel is one bit wider than the channel
   // a product of signed pixel and coefficient needs their summed widths
   logic signed [`CCM_PIXEL_WIDTH:0]                    pix_r;
   logic signed [`CCM_PIXEL_WIDTH:0]                    pix_g;
   logic signed [`CCM_PIXEL_WIDTH:0]                    pix_b;
   logic signed [`CCM_PIXEL_WIDTH+`CCM_COEFF_WIDTH:0]   prod_r_q;
   logic signed [`CCM_PIXEL_WIDTH+`CCM_COEFF_WIDTH:0]   prod_g_q;
   logic signed [`CCM_PIXEL_WIDTH+`CCM_COEFF_WIDTH:0]   prod_b_q;

   // zero sign bit keeps the unsigned channel positive in signed math
   assign pix_r = $signed({1'b0, beat.rgb.r});
   assign pix_g = $signed({1'b0, beat.rgb.g});
   assign pix_b = $signed({1'b0, beat.rgb.b});

   // stage 1, three products
   // beats with dv low are multiplied anyway, nobody looks at them
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         prod_r_q <= '0;
         prod_g_q <= '0;
         prod_b_q <= '0;
      end else begin
         prod_r_q <= pix_r * $signed(row.cr);
         prod_g_q <= pix_g * $signed(row.cg);
         prod_b_q <= pix_b * $signed(row.cb);
      end
   end

   // stage 2, sign-extended sum
   // two growth bits cover the worst case of three full-scale terms
   // no rounding here, the clamp stage floors the fraction
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         sum <= '0;
      end else begin
         sum <= ccm_coeff_pkg::mac_sum_t'(prod_r_q)
              + ccm_coeff_pkg::mac_sum_t'(prod_g_q)
              + ccm_coeff_pkg::mac_sum_t'(prod_b_q);
      end
   end

   // sideband is not needed here, only dv is watched
   // a valid beat must leave a sum two edges later that is not undefined
   a_sum_known : assert property (
      @(posedge clk) disable iff (!resetb)
      beat.dv |-> ##2 !$isunknown(sum)
   ) else $error("row sum unknown two cycles after a valid beat");

endmodule

//--- rtl/ccm_top.sv
`timescale 1ns/10ps
`include "ccm_defs.svh"

module ccm_top (
   input  logic                         clk,
   input  logic                         resetb,
   input  logic                         enable,
   input  logic                         coeff_we,
   input  ccm_coeff_pkg::coeff_addr_t   coeff_addr,
   input  ccm_coeff_pkg::coeff_t        coeff_data,
   input  pixel_pkg::pixel_beat_t       pixel_in,
   output pixel_pkg::pixel_beat_t       pixel_out
);

   // registered beat, shared by every row unit and the clamp stage
   pixel_pkg::pixel_beat_t beat_q;

   // one coefficient row per output channel
   ccm_coeff_pkg::coeff_row_t [`CCM_CHANNELS-1:0] rows;

   // one exact dot product per output channel
   ccm_coeff_pkg::mac_sum_t [`CCM_CHANNELS-1:0] sums;

   // latency budget
   // bank 1 cycle, row units 2 cycles, clamp stage 1 cycle
   // so a beat in before edge N is out after edge N+3

   // coefficient registers and input beat register
   ccm_coeff_bank u_bank (
      .clk        (clk),
      .resetb     (resetb),
      .coeff_we   (coeff_we),
      .coeff_addr (coeff_addr),
      .coeff_data (coeff_data),
      .pixel_in   (pixel_in),
      .beat_q     (beat_q),
      .rows       (rows)
   );

   // three identical dot products, channel 0 is r
   for (genvar ch = 0; ch < `CCM_CHANNELS; ch++) begin : g_row
      ccm_row_mac u_row_mac (
         .clk    (clk),
         .resetb (resetb),
         .beat   (beat_q),
         .row    (rows[ch]),
         .sum    (sums[ch])
      );
   end

   // floor, saturate, bypass select and output register
   ccm_clamp_stage u_clamp (
      .clk       (clk),
      .resetb    (resetb),
      .enable    (enable),
      .beat_q    (beat_q),
      .sums      (sums),
      .pixel_out (pixel_out)
   );

endmodule

//--- rtl/pixel_pkg.sv
`include "ccm_defs.svh"

package pixel_pkg;

   // one unsigned colour channel
   typedef logic [`CCM_PIXEL_WIDTH-1:0] pixel_t;

   // data type code, passed through untouched
   typedef logic [`CCM_DTYPE_WIDTH-1:0] dtype_t;

   // per-beat metadata word, passed through untouched
   typedef logic [`CCM_META_WIDTH-1:0] meta_t;

   // rgb triple, r in the top bits
   typedef struct packed {
      pixel_t r;
      pixel_t g;
      pixel_t b;
   } rgb_t;

   // one pipeline beat
   // dv is the only strobe, other fields are don't-care while it is low
   typedef struct packed {
      logic   dv;
      dtype_t dtype;
      meta_t  meta;
      rgb_t   rgb;
   } pixel_beat_t;

endpackage

//--- tests/ccm_golden.txt
# commands for tb_ccm, every number in hex
# W addr data        coefficient write, data is 8-bit two's complement and 20 is 1.0
# E level            1 gives the corrected pixel, 0 the raw pixel
# P dtype meta r g b er eg eb    pixel beat and its expected rgb
# Q                  wait until every expected beat has come out
# identity matrix after reset
E 1
P 1 0001 000 000 000 000 000 000
P 2 1234 3ff 000 155 3ff 000 155
P 3 abcd 123 2aa 3ff 123 2aa 3ff
P f ffff 001 200 0ff 001 200 0ff
Q
# rows r 1.5 -0.25 -0.25  g -0.125 1.25 -0.125  b 0 -0.5 1.5
W 0 30
W 1 f8
W 2 f8
W 3 fc
W 4 28
W 5 fc
W 6 00
W 7 f0
W 8 30
P 4 0100 064 0c8 12c 019 0c8 15e
P 4 0101 065 0ca 007 063 0ef 000
P 4 0102 001 000 000 001 000 000
P 4 0103 003 005 009 001 004 00b
P 4 0104 1f4 00a 280 24b 000 3bb
Q
# negative sums give zero and large sums give full scale
P 5 0200 3ff 000 000 3ff 000 000
P 5 0201 000 3ff 3ff 000 3ff 3ff
P 5 0202 3ff 3ff 3ff 3ff 3ff 3ff
Q
# bypass returns the raw pixel
E 0
P 6 0300 064 0c8 12c 064 0c8 12c
P 6 0301 3ff 000 000 3ff 000 000
Q
# correction again
E 1
P 7 0400 064 0c8 12c 019 0c8 15e
Q

//--- tests/tb_ccm.sv
`timescale 1ns/10ps
`include "ccm_defs.svh"

module tb_ccm;

   localparam int NCOEF          = `CCM_CHANNELS * `CCM_CHANNELS;
   // a beat taken by the bank on edge N leaves after edge N+3
   localparam int LATENCY_EDGES  = 3;
   localparam int QUIET_TIMEOUT  = 20;
   localparam int RESET_TIMEOUT  = 40;
   localparam int BURST_LEN      = 64;
   localparam int BURST_WRITE_AT = 32;
   // mid-burst write of GG to 0.75
   localparam ccm_coeff_pkg::coeff_addr_t BURST_ADDR = 4'd4;
   localparam ccm_coeff_pkg::coeff_t      BURST_DATA = 8'sh18;

   logic                         clk;
   logic                         resetb;
   logic                         enable;
   logic                         coeff_we;
   ccm_coeff_pkg::coeff_addr_t   coeff_addr;
   ccm_coeff_pkg::coeff_t        coeff_data;
   pixel_pkg::pixel_beat_t       pixel_in;
   pixel_pkg::pixel_beat_t       pixel_out;

   // expected beats in output order, with the edge each one entered the bank
   pixel_pkg::pixel_beat_t exp_q [$];
   int                     stamp_q [$];

   // mirror of the coefficient registers, plain integers
   int coeff_m [NCOEF];

   int          cycle_cnt = 0;
   int          value_errs;
   int          flow_errs;
   logic [31:0] lfsr_state;

   tb_clock_gen u_clock_gen (
      .clk    (clk),
      .resetb (resetb)
   );

   ccm_top dut (
      .clk        (clk),
      .resetb     (resetb),
      .enable     (enable),
      .coeff_we   (coeff_we),
      .coeff_addr (coeff_addr),
      .coeff_data (coeff_data),
      .pixel_in   (pixel_in),
      .pixel_out  (pixel_out)
   );

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   // 32-bit Galois LFSR, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 32'h8020_0003;
      end
      return n;
   endfunction

   // one step per bit taken, first bit lands on top
   function automatic logic [31:0] take_bits(input int nbits);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < nbits; i++) begin
         v = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_step(lfsr_state);
      end
      return v;
   endfunction

   // reference rule for one output channel
   // exact dot product, fraction floored, then saturated to the pixel range
   function automatic pixel_pkg::pixel_t model_channel(input int row, input pixel_pkg::rgb_t px);
      int acc;
      int whole;
      acc = int'(px.r) * coeff_m[row*`CCM_CHANNELS + 0]
          + int'(px.g) * coeff_m[row*`CCM_CHANNELS + 1]
          + int'(px.b) * coeff_m[row*`CCM_CHANNELS + 2];
      // arithmetic shift of a signed int rounds toward minus infinity
      whole = acc >>> `CCM_COEFF_FRAC;
      if (whole < 0) begin
         whole = 0;
      end else if (whole > (1 << `CCM_PIXEL_WIDTH) - 1) begin
         whole = (1 << `CCM_PIXEL_WIDTH) - 1;
      end
      return pixel_pkg::pixel_t'(whole);
   endfunction

   // one input cycle, all DUT inputs change on the falling edge
   task automatic drive_cycle(input pixel_pkg::pixel_beat_t beat, input pixel_pkg::rgb_t exp_rgb,
                              input logic we, input ccm_coeff_pkg::coeff_addr_t addr,
                              input ccm_coeff_pkg::coeff_t data);
      pixel_pkg::pixel_beat_t want;
      @(negedge clk);
      pixel_in   <= beat;
      coeff_we   <= we;
      coeff_addr <= addr;
      coeff_data <= data;
      if (beat.dv) begin
         want     = beat;
         want.rgb = exp_rgb;
         exp_q.push_back(want);
         // the bank takes this beat on the coming rising edge
         stamp_q.push_back(cycle_cnt + 1);
      end
   endtask

   task automatic write_coeff(input ccm_coeff_pkg::coeff_addr_t addr,
                              input ccm_coeff_pkg::coeff_t data);
      drive_cycle('0, '0, 1'b1, addr, data);
      coeff_m[int'(addr)] = int'(data);
   endtask

   // idle inputs, then wait until every expected beat has come out
   task automatic wait_quiet();
      int n;
      drive_cycle('0, '0, 1'b0, '0, '0);
      n = 0;
      while (exp_q.size() != 0 && n < QUIET_TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (exp_q.size() != 0) begin
         flow_errs++;
         $display("%0d expected beat(s) never came out of the DUT", exp_q.size());
         exp_q.delete();
         stamp_q.delete();
      end
   endtask

   // bypass level changes only with the pipeline empty
   task automatic set_enable(input logic level);
      wait_quiet();
      @(negedge clk);
      enable <= level;
   endtask

   task automatic run_golden();
      int                     fd;
      int                     got;
      string                  line;
      string                  args;
      byte                    c;
      logic [31:0]            a0, a1, a2, a3, a4, a5, a6, a7;
      pixel_pkg::pixel_beat_t beat;
      pixel_pkg::rgb_t        exp_rgb;
      fd = $fopen("tests/ccm_golden.txt", "r");
      if (fd == 0) begin
         flow_errs++;
         $display("cannot open tests/ccm_golden.txt");
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         got  = $fgets(line, fd);
         if (got == 0 || line.len() < 1) begin
            continue;
         end
         c    = line.getc(0);
         args = line.substr(1, line.len() - 1);
         if (c == "W") begin
            got = $sscanf(args, "%h %h", a0, a1);
            write_coeff(ccm_coeff_pkg::coeff_addr_t'(a0), ccm_coeff_pkg::coeff_t'(a1));
         end else if (c == "E") begin
            got = $sscanf(args, "%h", a0);
            set_enable(a0[0]);
         end else if (c == "Q") begin
            wait_quiet();
         end else if (c == "P") begin
            got = $sscanf(args, "%h %h %h %h %h %h %h %h", a0, a1, a2, a3, a4, a5, a6, a7);
            if (got != 8) begin
               flow_errs++;
               $display("malformed pixel line in golden file: %s", line);
               continue;
            end
            beat.dv     = 1'b1;
            beat.dtype  = pixel_pkg::dtype_t'(a0);
            beat.meta   = pixel_pkg::meta_t'(a1);
            beat.rgb.r  = pixel_pkg::pixel_t'(a2);
            beat.rgb.g  = pixel_pkg::pixel_t'(a3);
            beat.rgb.b  = pixel_pkg::pixel_t'(a4);
            exp_rgb.r   = pixel_pkg::pixel_t'(a5);
            exp_rgb.g   = pixel_pkg::pixel_t'(a6);
            exp_rgb.b   = pixel_pkg::pixel_t'(a7);
            drive_cycle(beat, exp_rgb, 1'b0, '0, '0);
         end else if (c != "#" && c != "\n" && c != "\r" && c != " ") begin
            flow_errs++;
            $display("unknown command in golden file: %s", line);
         end
      end
      $fclose(fd);
   endtask

   // 64 beats back to back, one coefficient write in the middle
   task automatic run_burst();
      pixel_pkg::pixel_beat_t beat;
      pixel_pkg::rgb_t        exp_rgb;
      logic                   we;
      set_enable(1'b1);
      for (int i = 0; i < BURST_LEN; i++) begin
         beat.dv    = 1'b1;
         beat.dtype = pixel_pkg::dtype_t'(take_bits(`CCM_DTYPE_WIDTH));
         beat.meta  = pixel_pkg::meta_t'(32'hb000 + i);
         beat.rgb.r = pixel_pkg::pixel_t'(take_bits(`CCM_PIXEL_WIDTH));
         beat.rgb.g = pixel_pkg::pixel_t'(take_bits(`CCM_PIXEL_WIDTH));
         beat.rgb.b = pixel_pkg::pixel_t'(take_bits(`CCM_PIXEL_WIDTH));
         exp_rgb.r  = model_channel(0, beat.rgb);
         exp_rgb.g  = model_channel(1, beat.rgb);
         exp_rgb.b  = model_channel(2, beat.rgb);
         we         = (i == BURST_WRITE_AT);
         drive_cycle(beat, exp_rgb, we, BURST_ADDR, BURST_DATA);
         // the beat sharing the write edge still uses the old matrix
         if (we) begin
            coeff_m[int'(BURST_ADDR)] = int'(BURST_DATA);
         end
      end
      wait_quiet();
   endtask

   // output check, half a cycle after the edge that updated pixel_out
   always @(negedge clk) begin
      pixel_pkg::pixel_beat_t want;
      int                     stamp;
      if (pixel_out.dv === 1'b1) begin
         if (exp_q.size() == 0) begin
            flow_errs++;
            $display("pixel_out.dv high with no beat outstanding at cycle %0d", cycle_cnt);
         end else begin
            want  = exp_q.pop_front();
            stamp = stamp_q.pop_front();
            if (cycle_cnt - stamp != LATENCY_EDGES) begin
               flow_errs++;
               $display("beat with meta %h came out %0d edges after the bank, not %0d",
                        want.meta, cycle_cnt - stamp, LATENCY_EDGES);
            end
            if (pixel_out.dtype !== want.dtype) begin
               value_errs++;
               $display("Fail pixel_out.dtype got %h expected %h", pixel_out.dtype, want.dtype);
            end
            if (pixel_out.meta !== want.meta) begin
               value_errs++;
               $display("Fail pixel_out.meta got %h expected %h", pixel_out.meta, want.meta);
            end
            if (pixel_out.rgb.r !== want.rgb.r) begin
               value_errs++;
               $display("Fail pixel_out.rgb.r got %h expected %h meta %h",
                        pixel_out.rgb.r, want.rgb.r, want.meta);
            end
            if (pixel_out.rgb.g !== want.rgb.g) begin
               value_errs++;
               $display("Fail pixel_out.rgb.g got %h expected %h meta %h",
                        pixel_out.rgb.g, want.rgb.g, want.meta);
            end
            if (pixel_out.rgb.b !== want.rgb.b) begin
               value_errs++;
               $display("Fail pixel_out.rgb.b got %h expected %h meta %h",
                        pixel_out.rgb.b, want.rgb.b, want.meta);
            end
         end
      end else if (pixel_out.dv !== 1'b0) begin
         flow_errs++;
         $display("pixel_out.dv is unknown at cycle %0d", cycle_cnt);
      end
   end

   initial begin
      int n;
      value_errs = 0;
      flow_errs  = 0;
      lfsr_state = 32'h290a;
      enable     = 1'b1;
      coeff_we   = 1'b0;
      coeff_addr = '0;
      coeff_data = '0;
      pixel_in   = '0;
      // identity matrix after reset
      for (int i = 0; i < NCOEF; i++) begin
         coeff_m[i] = 0;
      end
      for (int ch = 0; ch < `CCM_CHANNELS; ch++) begin
         coeff_m[ch*`CCM_CHANNELS + ch] = 1 << `CCM_COEFF_FRAC;
      end
      n = 0;
      while (resetb !== 1'b1 && n < RESET_TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (resetb !== 1'b1) begin
         flow_errs++;
         $display("reset was never released");
      end
      run_golden();
      run_burst();
      $display("errors %0d value, %0d flow", value_errs, flow_errs);
      if (value_errs + flow_errs == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
   output logic clk,
   output logic resetb
);

   // 10 ns period
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // reset low for the first 16 rising edges
   // released on a falling edge, away from the active edge
   initial begin
      resetb = 1'b0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      resetb = 1'b1;
   end

endmodule
